/* verilog/memSettings.svh */
`ifndef MEM_SETTINGS_SVH
`define MEM_SETTINGS_SVH

// Cache line geometry
// Words per line, kept a power of two
// so the offset field is a clean bit slice
`define LINE_WORDS 4

// Lines in each direct-mapped cache
// Also a power of two for the index field
`define CACHE_LINES 16

// Memory model size in 32-bit words
// 1024 words cover the first 4 KB
`define MEM_WORDS 1024

// Bus timing
// Cycles from the start of a transfer to its ready
// Applies to every word of a line fill
`define MEM_LATENCY 2

`endif

/* verilog/memPkg.sv */
`include "memSettings.svh"

package memPkg;

  // Data word on the core side and on the bus
  typedef logic [31:0] word_t;

  // Byte address as issued by the core
  typedef logic [31:0] addr_t;

  // One enable per byte lane, bit 0 is the low byte
  typedef logic [3:0] byteMask_t;

  // Address fields below the byte offset
  // Word within a line, bits 3:2
  typedef logic [$clog2(`LINE_WORDS)-1:0] offset_t;

  // Line select, bits 7:4
  typedef logic [$clog2(`CACHE_LINES)-1:0] index_t;

  // Everything above the index
  typedef logic [29 - $clog2(`LINE_WORDS) - $clog2(`CACHE_LINES):0] tag_t;

  // Instruction cache control
  typedef enum logic {
    fsIdle,
    fsFill
  } fillState_t;

  // Data cache control, write is one bus word
  typedef enum logic [1:0] {
    dsIdle,
    dsFill,
    dsWrite
  } dataState_t;

endpackage

/* verilog/busIf.sv */
`timescale 1ns/10ps

interface busIf;

  // Request side, driven by the cache
  memPkg::addr_t     haddr;
  logic              hwrite;
  logic              hrequest;
  memPkg::word_t     hwdata;
  memPkg::byteMask_t hbyteMask;

  // Response side, driven by the arbiter
  logic              hready;
  memPkg::word_t     hrdata;

  // Cache end of the link
  modport master (
    output haddr, hwrite, hrequest, hwdata, hbyteMask,
    input  hready, hrdata
  );

  // Arbiter end of the link
  modport arbiter (
    input  haddr, hwrite, hrequest, hwdata, hbyteMask,
    output hready, hrdata
  );

endinterface

/* verilog/instrCache.sv */
`timescale 1ns/10ps
`include "memSettings.svh"

module instrCache (
  input  logic          clk,
  input  logic          reset,
  input  logic          fetchEn,
  input  memPkg::addr_t fetchAddr,
  output memPkg::word_t instr,
  output logic          fetchStall,
  busIf.master          bus
);

  // Fields of the fetch address
  memPkg::tag_t    fetchTag;
  memPkg::index_t  fetchIndex;
  memPkg::offset_t fetchOffset;

  // Line storage
  memPkg::tag_t            tagArray  [`CACHE_LINES];
  memPkg::word_t           dataArray [`CACHE_LINES * `LINE_WORDS];
  logic [`CACHE_LINES-1:0] validBits;

  // Fill control
  memPkg::fillState_t state;
  memPkg::offset_t    beat;
  memPkg::tag_t       fillTag;
  memPkg::index_t     fillIndex;
  logic               hit;
  logic               startFill;
  logic               lastBeat;

  assign {fetchTag, fetchIndex, fetchOffset} = fetchAddr[31:2];

  // Lookup is purely combinational so a hit costs no cycle
  assign hit        = validBits[fetchIndex] && (tagArray[fetchIndex] == fetchTag);
  assign instr      = dataArray[{fetchIndex, fetchOffset}];
  assign fetchStall = fetchEn && !hit;

  assign startFill = (state == memPkg::fsIdle) && fetchEn && !hit;
  assign lastBeat  = bus.hready && (beat == memPkg::offset_t'(`LINE_WORDS - 1));

  // State, beat counter and valid bits
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= memPkg::fsIdle;
      beat      <= '0;
      validBits <= '0;
    end else begin
      case (state)
        memPkg::fsIdle: begin
          if (startFill) begin
            state <= memPkg::fsFill;
            beat  <= '0;
            // Line is rewritten word by word, so it is not valid meanwhile
            validBits[fetchIndex] <= 1'b0;
          end
        end
        memPkg::fsFill: begin
          if (bus.hready) begin
            beat <= beat + 1'b1;
          end
          if (lastBeat) begin
            validBits[fillIndex] <= 1'b1;
            state                <= memPkg::fsIdle;
          end
        end
        default: state <= memPkg::fsIdle;
      endcase
    end
  end

  // Tags and words
  always_ff @(posedge clk) begin
    if (startFill) begin
      fillTag              <= fetchTag;
      fillIndex            <= fetchIndex;
      tagArray[fetchIndex] <= fetchTag;
    end
    if ((state == memPkg::fsFill) && bus.hready) begin
      dataArray[{fillIndex, beat}] <= bus.hrdata;
    end
  end

  // Read-only master, one word per beat
  assign bus.hrequest  = (state == memPkg::fsFill);
  assign bus.haddr     = {fillTag, fillIndex, beat, 2'b00};
  assign bus.hwrite    = 1'b0;
  assign bus.hwdata    = '0;
  assign bus.hbyteMask = '1;

  // Address held across wait states
  assert property (@(posedge clk) disable iff (reset)
    bus.hrequest && !bus.hready |=> $stable(bus.haddr));

endmodule

/* verilog/dataCache.sv */
`timescale 1ns/10ps
`include "memSettings.svh"

module dataCache (
  input  logic              clk,
  input  logic              reset,
  input  logic              dataEn,
  input  logic              dataWrite,
  input  memPkg::addr_t     dataAddr,
  input  memPkg::word_t     writeData,
  input  memPkg::byteMask_t byteMask,
  output memPkg::word_t     readData,
  output logic              dataStall,
  busIf.master              bus
);

  // Fields of the access address
  memPkg::tag_t    dataTag;
  memPkg::index_t  dataIndex;
  memPkg::offset_t dataOffset;

  // Line storage
  memPkg::tag_t            tagArray  [`CACHE_LINES];
  memPkg::word_t           dataArray [`CACHE_LINES * `LINE_WORDS];
  logic [`CACHE_LINES-1:0] validBits;

  // Control
  memPkg::dataState_t state;
  memPkg::offset_t    beat;
  logic               writeDone;
  logic               hit;
  logic               startFill;
  logic               startWrite;
  logic               lastBeat;

  // Captured request that drives the bus
  memPkg::tag_t      reqTag;
  memPkg::index_t    reqIndex;
  memPkg::offset_t   reqOffset;
  memPkg::word_t     reqData;
  memPkg::byteMask_t reqMask;

  assign {dataTag, dataIndex, dataOffset} = dataAddr[31:2];

  assign hit      = validBits[dataIndex] && (tagArray[dataIndex] == dataTag);
  assign readData = dataArray[{dataIndex, dataOffset}];

  // Writes always wait for the bus and reads only on a miss
  // writeDone opens the one cycle in which the core sees the write finished
  assign dataStall = dataEn && (dataWrite ? !writeDone : !hit);

  assign startFill  = (state == memPkg::dsIdle) && dataEn && !dataWrite && !hit;
  assign startWrite = (state == memPkg::dsIdle) && dataEn && dataWrite && !writeDone;
  assign lastBeat   = bus.hready && (beat == memPkg::offset_t'(`LINE_WORDS - 1));

  // State, beat counter, valid bits, write completion
  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= memPkg::dsIdle;
      beat      <= '0;
      validBits <= '0;
      writeDone <= 1'b0;
    end else begin
      writeDone <= 1'b0;
      case (state)
        memPkg::dsIdle: begin
          if (startFill) begin
            state                <= memPkg::dsFill;
            beat                 <= '0;
            validBits[dataIndex] <= 1'b0;
          end else if (startWrite) begin
            state <= memPkg::dsWrite;
          end
        end
        memPkg::dsFill: begin
          if (bus.hready) begin
            beat <= beat + 1'b1;
          end
          if (lastBeat) begin
            validBits[reqIndex] <= 1'b1;
            state               <= memPkg::dsIdle;
          end
        end
        memPkg::dsWrite: begin
          // Single word with the byte merge done in the memory
          if (bus.hready) begin
            state     <= memPkg::dsIdle;
            writeDone <= 1'b1;
          end
        end
        default: state <= memPkg::dsIdle;
      endcase
    end
  end

  // Request capture, tags and words
  always_ff @(posedge clk) begin
    if (startFill || startWrite) begin
      reqTag    <= dataTag;
      reqIndex  <= dataIndex;
      reqOffset <= dataOffset;
      reqData   <= writeData;
      reqMask   <= byteMask;
    end
    if (startFill) begin
      tagArray[dataIndex] <= dataTag;
    end
    // Write hit keeps the cached copy in step with memory
    if (startWrite && hit) begin
      for (int b = 0; b < 4; b++) begin
        if (byteMask[b]) begin
          dataArray[{dataIndex, dataOffset}][8*b +: 8] <= writeData[8*b +: 8];
        end
      end
    end
    if ((state == memPkg::dsFill) && bus.hready) begin
      dataArray[{reqIndex, beat}] <= bus.hrdata;
    end
  end

  // Fill walks the line while a write uses the captured offset
  assign bus.hrequest  = (state != memPkg::dsIdle);
  assign bus.hwrite    = (state == memPkg::dsWrite);
  assign bus.haddr     = {reqTag, reqIndex,
                          (state == memPkg::dsWrite) ? reqOffset : beat, 2'b00};
  assign bus.hwdata    = reqData;
  assign bus.hbyteMask = (state == memPkg::dsWrite) ? reqMask : '1;

  // The bus answers only while this cache has a transfer open
  assert property (@(posedge clk) disable iff (reset)
    bus.hready |-> (state != memPkg::dsIdle));

endmodule

/* verilog/ahbArbiter.sv */
`timescale 1ns/10ps

module ahbArbiter (
  input  logic              clk,
  input  logic              reset,
  busIf.arbiter             fetchBus,
  busIf.arbiter             dataBus,
  output memPkg::addr_t     memAddr,
  output logic              memWrite,
  output logic              memRequest,
  output memPkg::word_t     memWData,
  output memPkg::byteMask_t memByteMask,
  input  logic              memReady,
  input  memPkg::word_t     memRData
);

  // Bus was in use last cycle
  logic locked;
  // Registered owner where 1 means the data side
  logic ownerData;
  logic ownerReq;
  logic grantData;

  assign ownerReq = ownerData ? dataBus.hrequest : fetchBus.hrequest;

  // Owner keeps the bus while it requests and the data side wins otherwise
  always_comb begin
    if (locked && ownerReq) begin
      grantData = ownerData;
    end else if (dataBus.hrequest) begin
      grantData = 1'b1;
    end else if (fetchBus.hrequest) begin
      grantData = 1'b0;
    end else begin
      grantData = ownerData;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      locked    <= 1'b0;
      ownerData <= 1'b0;
    end else begin
      locked    <= memRequest;
      ownerData <= grantData;
    end
  end

  // Request path to memory
  assign memRequest  = grantData ? dataBus.hrequest  : fetchBus.hrequest;
  assign memAddr     = grantData ? dataBus.haddr     : fetchBus.haddr;
  assign memWrite    = grantData ? dataBus.hwrite    : fetchBus.hwrite;
  assign memWData    = grantData ? dataBus.hwdata    : fetchBus.hwdata;
  assign memByteMask = grantData ? dataBus.hbyteMask : fetchBus.hbyteMask;

  // Losing side simply sees no ready
  assign fetchBus.hready = memReady && !grantData;
  assign dataBus.hready  = memReady && grantData;
  assign fetchBus.hrdata = memRData;
  assign dataBus.hrdata  = memRData;

  // Ready only reaches the master that still owns the word in flight
  assert property (@(posedge clk) disable iff (reset)
    memReady |-> memRequest && (grantData == ownerData));

endmodule

/* verilog/ahbMemory.sv */
`timescale 1ns/10ps
`include "memSettings.svh"

module ahbMemory (
  input  logic              clk,
  input  logic              reset,
  input  memPkg::addr_t     memAddr,
  input  logic              memWrite,
  input  logic              memRequest,
  input  memPkg::word_t     memWData,
  input  memPkg::byteMask_t memByteMask,
  output logic              memReady,
  output memPkg::word_t     memRData
);

  localparam int AddrBits  = $clog2(`MEM_WORDS);
  localparam int CountBits = $clog2(`MEM_LATENCY) + 1;

  memPkg::word_t        mem [`MEM_WORDS];
  logic [AddrBits-1:0]  wordIndex;
  logic [CountBits-1:0] count;
  logic                 lastCount;
  memPkg::word_t        readWord;

  // Word addressed, byte offset ignored
  assign wordIndex = memAddr[AddrBits+1:2];

  // Final wait cycle of the current word
  assign lastCount = memRequest && !memReady &&
                     (count == CountBits'(`MEM_LATENCY - 1));

  // Word i holds i * 0x01010101 with bit 31 inverted
  initial begin
    for (int i = 0; i < `MEM_WORDS; i++) begin
      mem[i] = (memPkg::word_t'(i) * 32'h0101_0101) ^ 32'h8000_0000;
    end
  end

  // Latency counter, restarts after every ready
  // Ready is a one cycle pulse per word
  always_ff @(posedge clk) begin
    if (reset) begin
      count    <= '0;
      memReady <= 1'b0;
    end else if (!memRequest || memReady) begin
      count    <= '0;
      memReady <= 1'b0;
    end else if (lastCount) begin
      count    <= '0;
      memReady <= 1'b1;
    end else begin
      count <= count + 1'b1;
    end
  end

  // Storage
  always @(posedge clk) begin
    // Read word registered as ready rises
    if (lastCount) begin
      readWord <= mem[wordIndex];
    end
    // Write lands on the completing edge, enabled lanes only
    if (memReady && memRequest && memWrite) begin
      for (int b = 0; b < 4; b++) begin
        if (memByteMask[b]) begin
          mem[wordIndex][8*b +: 8] <= memWData[8*b +: 8];
        end
      end
    end
  end

  assign memRData = readWord;

endmodule

/* verilog/memSubsystem.sv */
`timescale 1ns/10ps

module memSubsystem (
  input  logic              clk,
  input  logic              reset,
  input  logic              fetchEn,
  input  memPkg::addr_t     fetchAddr,
  output memPkg::word_t     instr,
  output logic              fetchStall,
  input  logic              dataEn,
  input  logic              dataWrite,
  input  memPkg::addr_t     dataAddr,
  input  memPkg::word_t     writeData,
  input  memPkg::byteMask_t byteMask,
  output memPkg::word_t     readData,
  output logic              dataStall
);

  // Cache to arbiter links
  busIf fetchBus ();
  busIf dataBus ();

  // Arbiter to memory
  memPkg::addr_t     memAddr;
  logic              memWrite;
  logic              memRequest;
  memPkg::word_t     memWData;
  memPkg::byteMask_t memByteMask;
  logic              memReady;
  memPkg::word_t     memRData;

  instrCache icache (
    .clk(clk), .reset(reset), .fetchEn(fetchEn), .fetchAddr(fetchAddr),
    .instr(instr), .fetchStall(fetchStall), .bus(fetchBus)
  );

  dataCache dcache (
    .clk(clk), .reset(reset), .dataEn(dataEn), .dataWrite(dataWrite),
    .dataAddr(dataAddr), .writeData(writeData), .byteMask(byteMask),
    .readData(readData), .dataStall(dataStall), .bus(dataBus)
  );

  // Single shared memory port
  ahbArbiter arbiter (
    .clk(clk), .reset(reset), .fetchBus(fetchBus), .dataBus(dataBus),
    .memAddr(memAddr), .memWrite(memWrite), .memRequest(memRequest),
    .memWData(memWData), .memByteMask(memByteMask),
    .memReady(memReady), .memRData(memRData)
  );

  ahbMemory mainMem (
    .clk(clk), .reset(reset), .memAddr(memAddr), .memWrite(memWrite),
    .memRequest(memRequest), .memWData(memWData), .memByteMask(memByteMask),
    .memReady(memReady), .memRData(memRData)
  );

endmodule

/* dv/memSubsystemTb.sv */
`timescale 1ns/10ps
`include "memSettings.svh"

module memSubsystemTb;

  // DUT inputs
  logic              clk;
  logic              reset;
  logic              fetchEn;
  memPkg::addr_t     fetchAddr;
  logic              dataEn;
  logic              dataWrite;
  memPkg::addr_t     dataAddr;
  memPkg::word_t     writeData;
  memPkg::byteMask_t byteMask;

  // DUT outputs
  memPkg::word_t instr;
  logic          fetchStall;
  memPkg::word_t readData;
  logic          dataStall;

  // Reference memory and the responses expected for the current access
  memPkg::word_t shadow [`MEM_WORDS];
  memPkg::word_t expInstr;
  memPkg::word_t expRead;
  logic          fetchHitExp;
  logic          loadHitExp;

  int seed = 83218;
  int accesses = 0;
  int errors = 0;
  int timeouts = 0;

  memSubsystem u_dut (
    .clk(clk), .reset(reset), .fetchEn(fetchEn), .fetchAddr(fetchAddr),
    .instr(instr), .fetchStall(fetchStall), .dataEn(dataEn), .dataWrite(dataWrite),
    .dataAddr(dataAddr), .writeData(writeData), .byteMask(byteMask),
    .readData(readData), .dataStall(dataStall)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // No stall and an idle bus on the first edge out of reset
  assert property (@(posedge clk) $fell(reset) |->
    !fetchStall && !dataStall && !u_dut.fetchBus.hrequest && !u_dut.dataBus.hrequest)
  else begin
    $display("Time %0t: a stall or a bus request was still high right after reset", $time);
    errors++;
  end

  // Fetch data whenever the fetch port is not stalled
  assert property (@(posedge clk) disable iff (reset)
    fetchEn && !fetchStall |-> instr == expInstr)
  else begin
    $display("CHECK FAILED at %0t: instr expected %h actual %h",
             $time, $sampled(expInstr), $sampled(instr));
    errors++;
  end

  // Load data only since writes return nothing
  assert property (@(posedge clk) disable iff (reset)
    dataEn && !dataWrite && !dataStall |-> readData == expRead)
  else begin
    $display("CHECK FAILED at %0t: readData expected %h actual %h",
             $time, $sampled(expRead), $sampled(readData));
    errors++;
  end

  // A hit answers in the cycle it is presented
  assert property (@(posedge clk) disable iff (reset) fetchHitExp |-> !fetchStall)
  else begin
    $display("CHECK FAILED at %0t: fetchStall expected 0 actual 1", $time);
    errors++;
  end

  assert property (@(posedge clk) disable iff (reset) loadHitExp |-> !dataStall)
  else begin
    $display("CHECK FAILED at %0t: dataStall expected 0 actual 1", $time);
    errors++;
  end

  // Write-through store holds the core until its bus word is done
  assert property (@(posedge clk) disable iff (reset)
    $rose(dataEn) && dataWrite |-> dataStall)
  else begin
    $display("CHECK FAILED at %0t: dataStall expected 1 actual 0", $time);
    errors++;
  end

  // Word in the reference memory
  function automatic memPkg::word_t expectedWord(input memPkg::addr_t addr);
    return shadow[addr[11:2]];
  endfunction

  // Byte lanes of a store land in the reference memory at issue
  function automatic void mergeShadow(input memPkg::addr_t addr, input memPkg::word_t value,
                                      input memPkg::byteMask_t mask);
    for (int b = 0; b < 4; b++) begin
      if (mask[b]) begin
        shadow[addr[11:2]][8*b +: 8] = value[8*b +: 8];
      end
    end
  endfunction

  // Waits for both stall signals to be low on a rising edge
  task automatic waitForStalls(input string what);
    int cycles;
    cycles = 0;
    @(posedge clk);
    while ((fetchStall || dataStall) && cycles < 200) begin
      @(posedge clk);
      cycles++;
    end
    if (fetchStall || dataStall) begin
      $display("Time %0t: %s was still stalled after 200 cycles", $time, what);
      timeouts++;
    end
    accesses++;
  endtask

  task automatic fetchWord(input memPkg::addr_t addr, input logic mustHit);
    @(negedge clk);
    fetchEn     = 1'b1;
    fetchAddr   = addr;
    expInstr    = expectedWord(addr);
    fetchHitExp = mustHit;
    waitForStalls("fetch");
    @(negedge clk);
    fetchEn     = 1'b0;
    fetchHitExp = 1'b0;
  endtask

  task automatic loadWord(input memPkg::addr_t addr, input logic mustHit);
    @(negedge clk);
    dataEn     = 1'b1;
    dataWrite  = 1'b0;
    dataAddr   = addr;
    expRead    = expectedWord(addr);
    loadHitExp = mustHit;
    waitForStalls("load");
    @(negedge clk);
    dataEn     = 1'b0;
    loadHitExp = 1'b0;
  endtask

  task automatic storeWord(input memPkg::addr_t addr, input memPkg::word_t value,
                           input memPkg::byteMask_t mask);
    @(negedge clk);
    dataEn    = 1'b1;
    dataWrite = 1'b1;
    dataAddr  = addr;
    writeData = value;
    byteMask  = mask;
    mergeShadow(addr, value, mask);
    waitForStalls("store");
    @(negedge clk);
    dataEn    = 1'b0;
    dataWrite = 1'b0;
  endtask

  // Both ports miss together so the arbiter has to serialize them
  task automatic fetchAndLoad(input memPkg::addr_t fAddr, input memPkg::addr_t dAddr);
    @(negedge clk);
    fetchEn   = 1'b1;
    fetchAddr = fAddr;
    expInstr  = expectedWord(fAddr);
    dataEn    = 1'b1;
    dataWrite = 1'b0;
    dataAddr  = dAddr;
    expRead   = expectedWord(dAddr);
    waitForStalls("fetch and load");
    @(negedge clk);
    fetchEn = 1'b0;
    dataEn  = 1'b0;
  endtask

  initial begin
    int kind;
    memPkg::addr_t addr;
    // Word i starts as i * 0x01010101 with the top bit flipped
    for (int i = 0; i < `MEM_WORDS; i++) begin
      shadow[i] = (32'(i) * 32'h0101_0101) ^ 32'h8000_0000;
    end
    reset       = 1'b1;
    fetchEn     = 1'b0;
    fetchAddr   = '0;
    dataEn      = 1'b0;
    dataWrite   = 1'b0;
    dataAddr    = '0;
    writeData   = '0;
    byteMask    = '0;
    expInstr    = '0;
    expRead     = '0;
    fetchHitExp = 1'b0;
    loadHitExp  = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Miss then hit in the same line
    fetchWord(32'h040, 1'b0);
    fetchWord(32'h044, 1'b1);
    // Store then load on a cached line and then on a line that is not cached
    loadWord(32'h820, 1'b0);
    storeWord(32'h820, $random(seed), memPkg::byteMask_t'($random(seed)));
    loadWord(32'h820, 1'b1);
    storeWord(32'h924, $random(seed), memPkg::byteMask_t'($random(seed)));
    loadWord(32'h924, 1'b0);
    // Simultaneous misses
    fetchAndLoad(32'h300, 32'hA40);
    // Index 5 with two tags where each load evicts the other
    for (int r = 0; r < 3; r++) begin
      loadWord(32'hB50, 1'b0);
      loadWord(32'hC50, 1'b0);
    end
    // Fetches stay below 2 KB and data above so the icache never goes stale
    for (int n = 0; n < 40; n++) begin
      kind = $unsigned($random(seed)) % 3;
      addr = $random(seed) & 32'h7FC;
      if (kind == 0) begin
        fetchWord(addr, 1'b0);
      end else if (kind == 1) begin
        loadWord(addr | 32'h800, 1'b0);
      end else begin
        storeWord(addr | 32'h800, $random(seed), memPkg::byteMask_t'($random(seed)));
      end
    end

    repeat (2) @(posedge clk);
    $display("Accesses: %0d  check failures: %0d  timeouts: %0d", accesses, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+verilog
verilog/memPkg.sv
verilog/busIf.sv
verilog/instrCache.sv
verilog/dataCache.sv
verilog/ahbArbiter.sv
verilog/ahbMemory.sv
verilog/memSubsystem.sv
dv/memSubsystemTb.sv

/* Makefile */
TOP = memSubsystemTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
